//--- lsu_pkg.sv
// Core-side types of the load/store unit. Only byte, halfword and word sizes exist.
// Addresses and data share one width.
`default_nettype none

package lsu_pkg;

  // Data and address width
  localparam int DATA_W = 32;

  // Access size as encoded by the core
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } lsu_size_e;

  // One core request, address is base plus offset
  typedef struct packed {
    logic              we;
    lsu_size_e         size;
    logic              sign_ext;
    logic [DATA_W-1:0] base;
    logic [DATA_W-1:0] offset;
    logic [DATA_W-1:0] wdata;
  } lsu_req_t;

  // What a load needs to build its result
  typedef struct packed {
    lsu_size_e   size;
    logic        sign_ext;
    logic [1:0]  ofs;
  } lsu_ctx_t;

  // One core response
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } lsu_rsp_t;

  // One bus phase, word address and lane-rotated store data
  typedef struct packed {
    logic [DATA_W-1:0]   adr;
    logic                we;
    logic [DATA_W/8-1:0] sel;
    logic [DATA_W-1:0]   wdata;
  } lsu_phase_t;

endpackage

`default_nettype wire

//--- wb_pkg.sv
// Wishbone classic master and slave signal groups, single data width.
// No tags, no burst signals.
`default_nettype none

package wb_pkg;

  // Byte address width
  localparam int WB_ADR_W = 32;
  // Byte selects, data is eight bits per select
  localparam int WB_SEL_W = 4;

  // Master outputs
  typedef struct packed {
    logic [WB_ADR_W-1:0]   adr;
    logic [WB_SEL_W*8-1:0] dat;
    logic [WB_SEL_W-1:0]   sel;
    logic                  we;
    logic                  cyc;
    logic                  stb;
  } wb_req_t;

  // Slave outputs
  typedef struct packed {
    logic [WB_SEL_W*8-1:0] dat;
    logic                  ack;
    logic                  err;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- lsu_request.sv
// Holds one core request until its response is taken. Misaligned words and
// halfwords at offset 3 split into two bus phases, lower word first.
`timescale 1ns/100ps
`default_nettype none

module lsu_request (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                req_valid_i,
  input  wire lsu_pkg::lsu_req_t   req_i,
  output logic                     req_ready_o,
  output logic                     rsp_valid_o,
  input  wire logic                rsp_ready_i,
  output logic                     phase_valid_o,
  output lsu_pkg::lsu_phase_t      phase_o,
  input  wire logic                phase_done_i,
  input  wire logic                phase_err_i,
  output lsu_pkg::lsu_ctx_t        ctx_o,
  output logic                     phase_last_o,
  output logic                     finish_o
);

  typedef enum logic [1:0] {st_idle, st_ph1, st_ph2, st_rsp} state_e;

  state_e                              state_q;
  state_e                              state_d;
  lsu_pkg::lsu_req_t                   req_q;
  logic                                accept;
  logic [lsu_pkg::DATA_W-1:0]          addr;
  logic [1:0]                          ofs;
  logic                                split;
  logic [lsu_pkg::DATA_W-3:0]          word_adr;
  logic [lsu_pkg::DATA_W/8-1:0]        size_mask;
  logic [2*lsu_pkg::DATA_W/8-1:0]      sel_wide;
  logic [2*lsu_pkg::DATA_W-1:0]        wdata_wide;

  ////////////////////
  // Request capture
  assign req_ready_o = (state_q == st_idle);
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req_q <= req_i;
    end
  end

  ////////////////////
  // Address and split decision
  assign addr = req_q.base + req_q.offset;
  assign ofs  = addr[1:0];
  // Word at any nonzero offset, or halfword crossing into the next word
  assign split = ((req_q.size == lsu_pkg::size_word) && (ofs != 2'b00)) ||
                 ((req_q.size == lsu_pkg::size_half) && (ofs == 2'b11));

  // Phase 2 addresses the following word
  assign word_adr = addr[lsu_pkg::DATA_W-1:2] +
                    {{(lsu_pkg::DATA_W-3){1'b0}}, (state_q == st_ph2)};

  // Lane mask before the offset shift
  always_comb
  begin
    case (req_q.size)
      lsu_pkg::size_byte: size_mask = 4'b0001;
      lsu_pkg::size_half: size_mask = 4'b0011;
      default:            size_mask = 4'b1111;
    endcase
  end

  // Low half feeds phase 1, overflow above lane 3 feeds phase 2
  assign sel_wide = {4'b0000, size_mask} << ofs;

  // Rotate store data left by the byte offset
  assign wdata_wide = {req_q.wdata, req_q.wdata} << {ofs, 3'b000};

  assign phase_o.adr   = {word_adr, 2'b00};
  assign phase_o.we    = req_q.we;
  assign phase_o.sel   = (state_q == st_ph2) ? sel_wide[7:4] : sel_wide[3:0];
  assign phase_o.wdata = wdata_wide[2*lsu_pkg::DATA_W-1:lsu_pkg::DATA_W];

  assign phase_valid_o = (state_q == st_ph1) || (state_q == st_ph2);
  assign phase_last_o  = (state_q == st_ph2) || !split;
  // An error in phase 1 ends the access early
  assign finish_o      = phase_valid_o && phase_done_i && (phase_last_o || phase_err_i);

  assign ctx_o.size     = req_q.size;
  assign ctx_o.sign_ext = req_q.sign_ext;
  assign ctx_o.ofs      = ofs;

  assign rsp_valid_o = (state_q == st_rsp);

  ////////////////////
  // Sequencer
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle: if (accept) state_d = st_ph1;
      st_ph1:
      begin
        if (phase_done_i)
        begin
          state_d = (split && !phase_err_i) ? st_ph2 : st_rsp;
        end
      end
      st_ph2: if (phase_done_i) state_d = st_rsp;
      st_rsp: if (rsp_ready_i) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= st_idle;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Every bus phase moves at least one byte
  a_sel_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    phase_valid_o |-> (phase_o.sel != '0));

  // Phase 2 only after a clean phase 1 whose lanes ran past the word end
  a_ph2_split: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(state_q == st_ph2) |-> $past(phase_done_i && !phase_err_i) &&
                                 (sel_wide[7:4] != '0));

endmodule

`default_nettype wire

//--- lsu_wb_master.sv
// Wishbone classic master, one cycle per phase and no pipelining. The phase
// must stay stable from phase_valid_i until phase_done_o.
`timescale 1ns/100ps
`default_nettype none

module lsu_wb_master (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         phase_valid_i,
  input  wire lsu_pkg::lsu_phase_t          phase_i,
  output logic                              phase_done_o,
  output logic [lsu_pkg::DATA_W-1:0]        phase_rdata_o,
  output logic                              phase_err_o,
  output wb_pkg::wb_req_t                   wb_o,
  input  wire wb_pkg::wb_rsp_t              wb_i
);

  logic cyc_q;
  logic term;

  // Slave terminates the cycle with ack or err
  assign term = cyc_q && (wb_i.ack || wb_i.err);

  ////////////////////
  // Cycle control
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cyc_q <= 1'b0;
    end
    else if (cyc_q)
    begin
      // Drop after termination, no restart in the same cycle
      if (term)
      begin
        cyc_q <= 1'b0;
      end
    end
    else if (phase_valid_i)
    begin
      cyc_q <= 1'b1;
    end
  end

  // Address and data come straight from the held phase
  assign wb_o.adr = phase_i.adr;
  assign wb_o.dat = phase_i.wdata;
  assign wb_o.sel = phase_i.sel;
  assign wb_o.we  = phase_i.we;
  assign wb_o.cyc = cyc_q;
  assign wb_o.stb = cyc_q;

  assign phase_done_o  = term;
  assign phase_rdata_o = wb_i.dat;
  assign phase_err_o   = cyc_q && wb_i.err;

  // Request side must not move while the slave is still deciding
  a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.stb && !(wb_i.ack || wb_i.err) |=>
      $stable(wb_o.adr) && $stable(wb_o.sel) && $stable(wb_o.we));

endmodule

`default_nettype wire

//--- lsu_rdata_align.sv
// Builds the load result from one or two bus phases and registers it.
// For stores the rdata field carries no meaning.
`timescale 1ns/100ps
`default_nettype none

module lsu_rdata_align (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic                         phase_done_i,
  input  wire logic [lsu_pkg::DATA_W-1:0]   phase_rdata_i,
  input  wire logic                         phase_err_i,
  input  wire lsu_pkg::lsu_ctx_t            ctx_i,
  input  wire logic                         phase_last_i,
  input  wire logic                         finish_i,
  output lsu_pkg::lsu_rsp_t                 rsp_o
);

  logic [lsu_pkg::DATA_W-1:0]   lo_q;
  logic                         lo_vld_q;
  logic [lsu_pkg::DATA_W-1:0]   lo_word;
  logic [2*lsu_pkg::DATA_W-1:0] wide;
  logic [lsu_pkg::DATA_W-1:0]   joined;
  logic [lsu_pkg::DATA_W-1:0]   ext;
  lsu_pkg::lsu_rsp_t            rsp_d;
  lsu_pkg::lsu_rsp_t            rsp_q;

  ////////////////////
  // Phase 1 capture
  always_ff @(posedge clk)
  begin
    if (phase_done_i && !phase_last_i)
    begin
      lo_q <= phase_rdata_i;
    end
  end

  // Marks held phase 1 data until the access finishes
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lo_vld_q <= 1'b0;
    end
    else if (finish_i)
    begin
      lo_vld_q <= 1'b0;
    end
    else if (phase_done_i)
    begin
      lo_vld_q <= !phase_last_i;
    end
  end

  ////////////////////
  // Join and extend
  // Single phase uses the current word for both halves
  assign lo_word = lo_vld_q ? lo_q : phase_rdata_i;
  // High bytes of phase 1 land at the bottom and phase 2 fills in above
  assign wide    = {phase_rdata_i, lo_word} >> {ctx_i.ofs, 3'b000};
  assign joined  = wide[lsu_pkg::DATA_W-1:0];

  always_comb
  begin
    case (ctx_i.size)
      lsu_pkg::size_byte:
      begin
        ext = {{24{ctx_i.sign_ext & joined[7]}}, joined[7:0]};
      end
      lsu_pkg::size_half:
      begin
        ext = {{16{ctx_i.sign_ext & joined[15]}}, joined[15:0]};
      end
      default:
      begin
        ext = joined;
      end
    endcase
  end

  assign rsp_d.rdata = ext;
  // A phase 1 error ends the access at once so only the finishing phase carries it
  assign rsp_d.err   = phase_err_i;

  // Response holds until the next access finishes
  always_ff @(posedge clk)
  begin
    if (finish_i)
    begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_o = rsp_q;

  // The sequencer may only finish on a bus termination
  // Held phase 1 data is always consumed by the last phase
  a_finish_done: assert property (@(posedge clk) disable iff (!rst_n)
    finish_i |-> phase_done_i && (phase_last_i || !lo_vld_q));

endmodule

`default_nettype wire

//--- lsu_top.sv
// Load/store unit with a valid/ready core port and a Wishbone classic bus.
// One request in flight, responses in order.
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                req_valid_i,
  input  wire lsu_pkg::lsu_req_t   req_i,
  output logic                     req_ready_o,
  output logic                     rsp_valid_o,
  output lsu_pkg::lsu_rsp_t        rsp_o,
  input  wire logic                rsp_ready_i,
  output wb_pkg::wb_req_t          wb_o,
  input  wire wb_pkg::wb_rsp_t     wb_i
);

  // Phase handshake between sequencer and bus master
  logic                         phase_valid;
  lsu_pkg::lsu_phase_t          phase;
  logic                         phase_done;
  logic [lsu_pkg::DATA_W-1:0]   phase_rdata;
  logic                         phase_err;
  // Load context towards the aligner
  lsu_pkg::lsu_ctx_t            ctx;
  logic                         phase_last;
  logic                         finish;

  lsu_request u_request (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_ready_i   (rsp_ready_i),
    .phase_valid_o (phase_valid),
    .phase_o       (phase),
    .phase_done_i  (phase_done),
    .phase_err_i   (phase_err),
    .ctx_o         (ctx),
    .phase_last_o  (phase_last),
    .finish_o      (finish)
  );

  lsu_wb_master u_wb_master (
    .clk           (clk),
    .rst_n         (rst_n),
    .phase_valid_i (phase_valid),
    .phase_i       (phase),
    .phase_done_o  (phase_done),
    .phase_rdata_o (phase_rdata),
    .phase_err_o   (phase_err),
    .wb_o          (wb_o),
    .wb_i          (wb_i)
  );

  lsu_rdata_align u_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .phase_done_i  (phase_done),
    .phase_rdata_i (phase_rdata),
    .phase_err_i   (phase_err),
    .ctx_i         (ctx),
    .phase_last_i  (phase_last),
    .finish_i      (finish),
    .rsp_o         (rsp_o)
  );

endmodule

`default_nettype wire

//--- tb_wb_mem.sv
// Wishbone classic slave, 64 words that wrap on address bits 7:2, zero at start.
// Bit 31 set answers err. Ack or err follows delay_i wait cycles.
`timescale 1ns/100ps
`default_nettype none

module tb_wb_mem (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire wb_pkg::wb_req_t    wb_i,
  output wb_pkg::wb_rsp_t         wb_o,
  input  wire logic [1:0]         delay_i
);

  logic [wb_pkg::WB_SEL_W*8-1:0] mem [64];
  logic [wb_pkg::WB_SEL_W*8-1:0] merged;
  logic [5:0]                    idx;
  logic [1:0]                    wait_cnt;
  logic                          pending;
  logic                          answer;

  assign idx     = wb_i.adr[7:2];
  // Strobe not yet answered
  assign pending = wb_i.cyc && wb_i.stb && !wb_o.ack && !wb_o.err;
  assign answer  = pending && (wait_cnt == delay_i);

  initial
  begin
    for (int w = 0; w < 64; w++)
      mem[w] = '0;
  end

  // Old word with the selected bytes replaced
  always_comb
  begin
    merged = mem[idx];
    for (int b = 0; b < wb_pkg::WB_SEL_W; b++)
    begin
      if (wb_i.sel[b])
        merged[8*b +: 8] = wb_i.dat[8*b +: 8];
    end
  end

  always @(posedge clk)
  begin
    if (answer && wb_i.we && !wb_i.adr[31])
      mem[idx] <= merged;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wait_cnt <= '0;
      wb_o     <= '0;
    end
    else
    begin
      wb_o.ack <= 1'b0;
      wb_o.err <= 1'b0;
      if (answer)
      begin
        wait_cnt <= '0;
        wb_o.ack <= !wb_i.adr[31];
        wb_o.err <= wb_i.adr[31];
        wb_o.dat <= wb_i.adr[31] ? '0 : mem[idx];
      end
      else if (pending)
      begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_lsu.sv
// Reads lsu_patterns.txt from the project root, eight hex fields per request.
// Stops at the first error. The memory model answers after 0 to 3 wait cycles.
`timescale 1ns/100ps
`default_nettype none

module tb_lsu;

  localparam int          CLK_PERIOD = 8;
  localparam int          RST_CYCLES = 16;
  localparam logic [31:0] LFSR_SEED  = 32'h2e01;
  localparam int          TIMEOUT    = 100;
  localparam string       PAT_FILE   = "lsu_patterns.txt";
  localparam int          MAX_PAT    = 64;
  localparam int          PAT_WORDS  = 8;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  lsu_pkg::lsu_req_t  req;
  logic               req_ready;
  logic               rsp_valid;
  lsu_pkg::lsu_rsp_t  rsp;
  logic               rsp_ready;
  wb_pkg::wb_req_t    wb_req;
  wb_pkg::wb_rsp_t    wb_rsp;
  logic [1:0]         mem_delay;
  logic [31:0]        lfsr;
  // Flat pattern store, PAT_WORDS entries per request
  logic [31:0]        pat [MAX_PAT*PAT_WORDS];

  lsu_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready),
    .wb_o        (wb_req),
    .wb_i        (wb_rsp)
  );

  tb_wb_mem u_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_i    (wb_req),
    .wb_o    (wb_rsp),
    .delay_i (mem_delay)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////
  // Random source
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int nbits, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr = lfsr_step(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  ////////////////////
  // Error handling and compares
  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string msg);
    fail_stop($sformatf("Mismatch at %0t: %s", $time, msg));
  endtask

  task automatic check_rsp(input lsu_pkg::lsu_rsp_t got, input lsu_pkg::lsu_rsp_t exp,
                           input logic cmp_data, input string what);
    if (got.err !== exp.err)
    begin
      report_mismatch($sformatf("%s err %0b, expected %0b", what, got.err, exp.err));
    end
    // Store data and errored loads carry no rdata
    if (cmp_data && (got.rdata !== exp.rdata))
    begin
      report_mismatch($sformatf("%s rdata %08h, expected %08h", what, got.rdata, exp.rdata));
    end
  endtask

  task automatic check_idle(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      report_mismatch($sformatf("%s req_ready_o %0b, expected %0b", what, got, exp));
    end
  endtask

  ////////////////////
  // Waits, sampled at falling edges
  task automatic wait_req_ready(input string what);
    int cnt;
    cnt = 0;
    while (req_ready !== 1'b1)
    begin
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT)
        fail_stop($sformatf("%s: unit never became ready for a request", what));
    end
  endtask

  task automatic wait_rsp_valid(input string what);
    int cnt;
    cnt = 0;
    while (rsp_valid !== 1'b1)
    begin
      // No new request may be taken while one is in flight
      check_idle(req_ready, 1'b0, what);
      @(negedge clk);
      cnt++;
      if (cnt > TIMEOUT)
        fail_stop($sformatf("%s: no response within %0d cycles", what, TIMEOUT));
    end
  endtask

  ////////////////////
  // One request from the pattern table
  task automatic run_pattern(input int n);
    int                 b;
    string              what;
    logic [7:0]         bits;
    logic               is_load;
    lsu_pkg::lsu_rsp_t  exp;
    lsu_pkg::lsu_rsp_t  held;
    b    = n * PAT_WORDS;
    what = $sformatf("pattern %0d", n);
    wait_req_ready(what);
    // Slave wait states for this access
    draw_bits(2, bits);
    mem_delay    = bits[1:0];
    req.we       = pat[b][0];
    req.size     = lsu_pkg::lsu_size_e'(pat[b+1][1:0]);
    req.sign_ext = pat[b+2][0];
    req.base     = pat[b+3];
    req.offset   = pat[b+4];
    req.wdata    = pat[b+5];
    exp.rdata    = pat[b+6];
    exp.err      = pat[b+7][0];
    is_load      = !pat[b][0];
    req_valid    = 1'b1;
    @(negedge clk);
    req_valid = 1'b0;
    wait_rsp_valid(what);
    // Back-pressure, response must hold still
    held = rsp;
    draw_bits(2, bits);
    for (int i = 0; i < int'(bits[1:0]); i++)
    begin
      @(negedge clk);
      if (rsp_valid !== 1'b1)
        fail_stop($sformatf("%s: response dropped while not taken", what));
      check_rsp(rsp, held, 1'b1, {what, " under back-pressure"});
      check_idle(req_ready, 1'b0, what);
    end
    check_rsp(rsp, exp, is_load && !exp.err, what);
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    if (rsp_valid !== 1'b0)
      fail_stop($sformatf("%s: response still valid after it was taken", what));
    // Ready again in the cycle after the response is taken
    check_idle(req_ready, 1'b1, {what, " after response"});
  endtask

  ////////////////////
  // Main sequence
  initial
  begin
    int n;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    mem_delay = 2'd0;
    lfsr      = LFSR_SEED;
    // All ones marks the end of the table
    for (int i = 0; i < MAX_PAT*PAT_WORDS; i++)
      pat[i] = '1;
    $readmemh(PAT_FILE, pat);
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if ((rsp_valid !== 1'b0) || (wb_req.cyc !== 1'b0) || (wb_req.stb !== 1'b0))
      fail_stop("response or bus cycle active right after reset");
    check_idle(req_ready, 1'b1, "after reset");
    n = 0;
    while ((n < MAX_PAT) && (pat[n*PAT_WORDS] !== '1))
    begin
      run_pattern(n);
      n++;
    end
    if (n == 0)
      fail_stop("no requests could be read from the pattern file");
    $display("%0d requests checked", n);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- lsu_patterns.txt
// we size sign_ext base offset wdata exp_rdata exp_err, all hex
// size 0 byte, 1 halfword, 2 word; exp_rdata is ignored for stores
// Aligned word store and load back
1 2 0 00000010 00000000 9C42E57A 00000000 0
0 2 0 00000008 00000008 00000000 9C42E57A 0
// Byte loads at every offset
0 0 0 00000010 00000000 00000000 0000007A 0
0 0 1 00000010 00000001 00000000 FFFFFFE5 0
0 0 0 00000011 00000000 00000000 000000E5 0
0 0 1 00000012 00000000 00000000 00000042 0
0 0 1 00000013 00000000 00000000 FFFFFF9C 0
0 0 0 00000010 00000003 00000000 0000009C 0
// Halfword loads at offsets 0 to 2
0 1 1 00000010 00000000 00000000 FFFFE57A 0
0 1 0 00000010 00000000 00000000 0000E57A 0
0 1 1 00000011 00000000 00000000 000042E5 0
0 1 1 00000012 00000000 00000000 FFFF9C42 0
0 1 0 00000012 00000000 00000000 00009C42 0
// Neighbour words, then misaligned stores at offsets 1 2 3
1 2 0 00000020 00000000 11223344 00000000 0
1 2 0 00000024 00000000 55667788 00000000 0
1 2 0 00000028 00000000 CAFEF00D 00000000 0
1 2 0 00000020 00000001 A1B2C3D4 00000000 0
0 2 0 00000021 00000000 00000000 A1B2C3D4 0
0 2 0 00000020 00000000 00000000 B2C3D444 0
0 2 0 00000024 00000000 00000000 556677A1 0
1 2 0 00000026 00000000 0BADBEEF 00000000 0
0 2 0 00000024 00000000 00000000 BEEF77A1 0
0 2 0 00000028 00000000 00000000 CAFE0BAD 0
1 2 0 0000002B 00000000 13579BDF 00000000 0
0 2 0 0000002B 00000000 00000000 13579BDF 0
0 2 0 00000028 00000000 00000000 DFFE0BAD 0
0 2 0 0000002C 00000000 00000000 0013579B 0
0 2 0 00000026 00000000 00000000 0BADBEEF 0
0 0 0 00000025 00000000 00000000 00000077 0
// Halfword split at offset 3, single phase at offset 1
0 1 1 00000023 00000000 00000000 FFFFA1B2 0
0 1 0 00000020 00000003 00000000 0000A1B2 0
1 1 0 0000002F 00000000 00008421 00000000 0
0 1 1 0000002F 00000000 00000000 FFFF8421 0
0 2 0 0000002C 00000000 00000000 2113579B 0
1 1 0 00000031 00000000 00007E5D 00000000 0
0 1 1 00000031 00000000 00000000 00007E5D 0
0 2 0 00000030 00000000 00000000 007E5D84 0
// Bus errors, second word only, first word only
0 2 0 80000000 00000000 00000000 00000000 1
1 0 0 80000010 00000000 000000AA 00000000 1
0 2 0 7FFFFFF0 0000000E 00000000 00000000 1
0 2 0 FFFFFFFF 00000000 00000000 00000000 1
0 2 0 00000010 00000000 00000000 9C42E57A 0

//--- flist.f
lsu_pkg.sv
wb_pkg.sv
lsu_request.sv
lsu_wb_master.sv
lsu_rdata_align.sv
lsu_top.sv
tb_wb_mem.sv
tb_lsu.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run from the project root
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_lsu -f flist.f &&
./obj_dir/Vtb_lsu | tee /dev/stderr | grep "TEST PASSED" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
